// ==== sim/cache_stim.txt ====
// op (0 read, 1 write), address, write data, expected read data, hit latency
// hit latency 0 marks a miss whose length is not checked
00000000 00000010 00000000 5a5a0010 00000000
00000000 00000010 00000000 5a5a0010 00000003
00000001 00000014 deadbeef 00000000 00000003
00000000 00000014 00000000 deadbeef 00000003
00000000 00000018 00000000 5a5a0018 00000003
00000001 00000020 11111111 00000000 00000000
00000001 000000a4 22222222 00000000 00000000
00000001 00000128 33333333 00000000 00000000
00000000 00000020 00000000 11111111 00000000
00000000 000000a4 00000000 22222222 00000000
00000000 00000128 00000000 33333333 00000000
00000000 0000012c 00000000 5a5a012c 00000003
00000000 000000a0 00000000 5a5a00a0 00000003
00000000 00001074 00000000 5a5a1074 00000000
00000001 00001078 cafef00d 00000000 00000003
00000000 00001078 00000000 cafef00d 00000003
00000000 00000014 00000000 deadbeef 00000003
00000000 00000094 00000000 5a5a0094 00000000
00000000 00000114 00000000 5a5a0114 00000000
00000000 00000014 00000000 deadbeef 00000000

// ==== filelist.f ====
source/cache_pkg.sv
source/req_latch.sv
source/cache_way.sv
source/way_select.sv
source/cache_ctrl.sv
source/blocking_cache.sv
sim/cache_properties.sv
sim/tb_blocking_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_blocking_cache
FILELIST  = filelist.f
BUILD_DIR = build
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_blocking_cache.sv ====
// Testbench for the blocking cache with clock, reset, memory model,
// file-driven stimulus, random back-pressure and final report
`timescale 1ns/10ps
`default_nettype none

module tb_blocking_cache
  import cache_pkg::*;
();

  localparam int          max_trans          = 64;
  localparam int          stim_words         = max_trans * 5;
  localparam int          cycles_per_line    = 200;
  localparam int          expected_evictions = 4;
  localparam logic [31:0] pattern            = 32'h5a5a0000;

  logic        clk;
  logic        reset;
  logic        req_val;
  logic        req_rdy;
  cache_req_t  req;
  logic        resp_val;
  logic        resp_rdy;
  cache_resp_t resp;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_req_t    mem_req;
  logic        mem_resp_val;
  logic        mem_resp_rdy;
  mem_resp_t   mem_resp;

  // Five columns per transaction of op, address, write data, expected data and hit latency
  logic [31:0]          stim [stim_words];
  logic [31:0]          shadow [logic [31:0]];
  logic [line_bits-1:0] mem_lines [logic [31:0]];
  logic [31:0]          rng        = 32'h7e61;
  int                   num_trans  = 0;
  int                   errors     = 0;
  int                   cycles     = 0;
  int                   req_cycle  = 0;
  int                   done_count = 0;
  int                   evictions  = 0;

  blocking_cache i_blocking_cache (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Last written value of a word or its memory pattern
  function automatic logic [31:0] expected_word(input logic [31:0] a);
    if (shadow.exists(a)) return shadow[a];
    return a ^ pattern;
  endfunction

  function automatic logic [line_bits-1:0] read_line(input logic [31:0] a);
    logic [line_bits-1:0] l;
    if (mem_lines.exists(a)) return mem_lines[a];
    for (int i = 0; i < words_per_line; i++) begin
      l[i*data_bits +: data_bits] = (a + 32'(4 * i)) ^ pattern;
    end
    return l;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  // Victim line must carry every word the stimulus wrote to it
  task automatic write_back(input mem_req_t r);
    evictions++;
    for (int i = 0; i < words_per_line; i++) begin
      check_value("evicted word", r.data[i*data_bits +: data_bits],
                  expected_word(r.addr + 32'(4 * i)));
    end
    mem_lines[r.addr] = r.data;
  endtask

  // ------------------------------------------------------------
  // Memory model and back-pressure
  // ------------------------------------------------------------
  initial begin : memory_model
    logic [line_bits-1:0] line;
    int                   countdown;
    logic                 busy;
    logic                 resp_done;
    mem_req_rdy  = 1'b0;
    resp_rdy     = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    line         = '0;
    countdown    = 0;
    busy         = 1'b0;
    forever begin
      @(posedge clk);
      resp_done = mem_resp_val && mem_resp_rdy;
      if (resp_done) busy = 1'b0;
      if (mem_req_val && mem_req_rdy) begin
        busy      = 1'b1;
        countdown = 1 + int'(rng[27:26]);
        line      = '0;
        if (mem_req.op == op_write) begin
          write_back(mem_req);
        end else begin
          line = read_line(mem_req.addr);
        end
      end
      @(negedge clk);
      rng         = lcg_next(rng);
      resp_rdy    = rng[31:30] != 2'b00;
      mem_req_rdy = !busy && (rng[29:28] != 2'b00);
      if (resp_done) mem_resp_val = 1'b0;
      if (countdown > 0) begin
        countdown--;
        if (countdown == 0) begin
          mem_resp_val  = 1'b1;
          mem_resp.data = line;
        end
      end
    end
  end

  // Responses come back in request order
  initial begin : response_monitor
    logic pending;
    int   base;
    pending = 1'b0;
    forever begin
      @(posedge clk);
      if (!reset && resp_val && done_count >= num_trans) begin
        errors++;
        $display("unexpected response at %0t with no request left", $time);
      end else if (!reset && resp_val) begin
        base = 5 * done_count;
        if (!pending && stim[base + 4] != 0) begin
          check_value("hit latency", cycles - req_cycle, stim[base + 4]);
        end
        pending = 1'b1;
        if (resp_rdy) begin
          check_value("response op", 32'(resp.op), 32'(stim[base][0]));
          if (stim[base][0] == op_read) begin
            check_value("read data", resp.data, stim[base + 3]);
          end
          pending = 1'b0;
          done_count++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (num_trans > 0 && cycles > cycles_per_line * num_trans) begin
      $display("timeout after %0d cycles, only %0d of %0d responses arrived",
               cycles, done_count, num_trans);
      $display("errors %0d, responses %0d of %0d, evictions %0d",
               errors, done_count, num_trans, evictions);
      $display("test failed");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Reset and stimulus
  // ------------------------------------------------------------
  initial begin : driver
    reset   = 1'b1;
    req_val = 1'b0;
    req     = '0;
    for (int i = 0; i < stim_words; i++) begin
      stim[i] = '1;
    end
    $readmemh("sim/cache_stim.txt", stim);
    while (num_trans < max_trans && stim[5 * num_trans] != '1) begin
      num_trans++;
    end
    if (num_trans == 0) begin
      errors++;
      $display("no transactions were read from the stimulus file");
    end

    // Two rising edges with reset high
    @(negedge clk);
    @(negedge clk);
    check_value("req_rdy in reset", 32'(req_rdy), 32'd1);
    check_value("resp_val in reset", 32'(resp_val), 32'd0);
    check_value("mem_req_val in reset", 32'(mem_req_val), 32'd0);
    check_value("mem_resp_rdy in reset", 32'(mem_resp_rdy), 32'd0);
    reset = 1'b0;
    @(negedge clk);
    check_value("req_rdy after reset", 32'(req_rdy), 32'd1);
    check_value("resp_val after reset", 32'(resp_val), 32'd0);
    check_value("mem_req_val after reset", 32'(mem_req_val), 32'd0);
    check_value("mem_resp_rdy after reset", 32'(mem_resp_rdy), 32'd0);

    for (int n = 0; n < num_trans; n++) begin
      req.op       = stim[5 * n][0];
      req.addr.raw = stim[5 * n + 1];
      req.data     = stim[5 * n + 2];
      req_val      = 1'b1;
      do begin
        @(posedge clk);
      end while (!req_rdy);
      req_cycle = cycles;
      if (req.op == op_write) shadow[req.addr.raw] = req.data;
      @(negedge clk);
    end
    req_val = 1'b0;

    while (done_count < num_trans) @(negedge clk);
    check_value("eviction count", evictions, expected_evictions);
    $display("errors %0d, responses %0d of %0d, evictions %0d",
             errors, done_count, num_trans, evictions);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/cache_properties.sv ====
// Handshake stability and reset assertions
// bound into the blocking cache top level
`timescale 1ns/10ps
`default_nettype none

module cache_properties
  import cache_pkg::*;
(
  input logic        clk,
  input logic        reset,
  input logic        req_val,
  input logic        req_rdy,
  input cache_req_t  req,
  input logic        resp_val,
  input logic        resp_rdy,
  input cache_resp_t resp,
  input logic        mem_req_val,
  input logic        mem_req_rdy,
  input mem_req_t    mem_req,
  input logic        mem_resp_rdy
);

  // Processor holds its request until the cache takes it
  assert property (@(posedge clk) disable iff (reset)
    req_val && !req_rdy |=> req_val && $stable(req))
    else $error("processor request changed before its transfer");

  assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else $error("cache response changed before its transfer");

  assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req))
    else $error("memory request changed before its transfer");

  // Blocking cache never offers a response and takes a request at once
  assert property (@(posedge clk) disable iff (reset)
    !(resp_val && req_rdy))
    else $error("resp_val and req_rdy high together");

  assert property (@(posedge clk)
    reset |=> !resp_val && !mem_req_val && !mem_resp_rdy && req_rdy)
    else $error("outputs not in their idle state after reset");

endmodule

bind blocking_cache cache_properties i_cache_properties (
  .clk          (clk),
  .reset        (reset),
  .req_val      (req_val),
  .req_rdy      (req_rdy),
  .req          (req),
  .resp_val     (resp_val),
  .resp_rdy     (resp_rdy),
  .resp         (resp),
  .mem_req_val  (mem_req_val),
  .mem_req_rdy  (mem_req_rdy),
  .mem_req      (mem_req),
  .mem_resp_rdy (mem_resp_rdy)
);

`default_nettype wire

// ==== source/blocking_cache.sv ====
// Two-way write-back blocking cache top level with
// request latch, ways, way selector and controller
`timescale 1ns/10ps
`default_nettype none

module blocking_cache
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        req_val,
  output logic        req_rdy,
  input  cache_req_t  req,
  output logic        resp_val,
  input  logic        resp_rdy,
  output cache_resp_t resp,
  output logic        mem_req_val,
  input  logic        mem_req_rdy,
  output mem_req_t    mem_req,
  input  logic        mem_resp_val,
  output logic        mem_resp_rdy,
  input  mem_resp_t   mem_resp
);

  cache_req_t                         cur;
  way_cmd_t                           cmd;
  logic                               capture;
  logic                               record;
  logic                               lru_update;
  logic                               mem_is_write;
  logic                               hit;
  logic                               victim_dirty;
  logic [num_ways-1:0]                hits;
  logic [num_ways-1:0]                dirties;
  logic [num_ways-1:0]                wens;
  logic [num_ways-1:0][tag_bits-1:0]  tags;
  logic [num_ways-1:0][line_bits-1:0] lines;
  logic [data_bits-1:0]               rd_word;
  mem_req_t                           victim_req;
  mem_req_t                           refill_req;

  req_latch u_req_latch (
    .clk     (clk),
    .reset   (reset),
    .capture (capture),
    .req     (req),
    .cur     (cur)
  );

  // ------------------------------------------------------------
  // Ways
  // ------------------------------------------------------------
  for (genvar w = 0; w < num_ways; w++) begin : g_way
    cache_way u_way (
      .clk       (clk),
      .reset     (reset),
      .cur       (cur),
      .cmd       (cmd),
      .wen       (wens[w]),
      .fill_line (mem_resp),
      .hit       (hits[w]),
      .dirty     (dirties[w]),
      .tag       (tags[w]),
      .line      (lines[w])
    );
  end

  way_select u_way_select (
    .clk          (clk),
    .reset        (reset),
    .cur          (cur),
    .hits         (hits),
    .dirties      (dirties),
    .tags         (tags),
    .lines        (lines),
    .record       (record),
    .lru_update   (lru_update),
    .cmd          (cmd),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .wens         (wens),
    .rd_word      (rd_word),
    .victim_req   (victim_req)
  );

  cache_ctrl u_cache_ctrl (
    .clk          (clk),
    .reset        (reset),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .is_write     (cur.op == op_write),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .capture      (capture),
    .record       (record),
    .lru_update   (lru_update),
    .cmd          (cmd),
    .mem_is_write (mem_is_write)
  );

  // Refill reads the whole line at the request address
  assign refill_req.op   = op_read;
  assign refill_req.addr = {cur.addr.raw[addr_bits-1:word_off_bits+byte_off_bits],
                            {(word_off_bits + byte_off_bits){1'b0}}};
  assign refill_req.data = '0;

  assign mem_req = mem_is_write ? victim_req : refill_req;

  assign resp.op   = cur.op;
  assign resp.data = rd_word;

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
// Transaction FSM of the blocking cache with its
// handshake, way command and LRU outputs
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     req_val,
  output logic     req_rdy,
  output logic     resp_val,
  input  logic     resp_rdy,
  output logic     mem_req_val,
  input  logic     mem_req_rdy,
  input  logic     mem_resp_val,
  output logic     mem_resp_rdy,
  input  logic     is_write,
  input  logic     hit,
  input  logic     victim_dirty,
  output logic     capture,
  output logic     record,
  output logic     lru_update,
  output way_cmd_t cmd,
  output logic     mem_is_write
);

  // One row of the output table
  typedef struct packed {
    logic req_rdy;
    logic resp_val;
    logic mem_req_val;
    logic mem_resp_rdy;
    logic capture;
    logic record;
    logic lru_update;
    logic fill;
    logic store;
    logic mem_is_write;
  } ctrl_out_t;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  ctrl_out_t   co;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (req_val) state_d = TAG_CHECK;
      end
      TAG_CHECK: begin
        if (hit) begin
          state_d = is_write ? WRITE_ACCESS : READ_ACCESS;
        end else begin
          state_d = victim_dirty ? EVICT_REQ : REFILL_REQ;
        end
      end
      READ_ACCESS:   state_d = WAIT;
      WRITE_ACCESS:  state_d = WAIT;
      WAIT: begin
        if (resp_rdy) state_d = IDLE;
      end
      REFILL_REQ: begin
        if (mem_req_rdy) state_d = REFILL_WAIT;
      end
      // Response is held by memory until accepted in REFILL_UPDATE
      REFILL_WAIT: begin
        if (mem_resp_val) state_d = REFILL_UPDATE;
      end
      REFILL_UPDATE: state_d = is_write ? WRITE_ACCESS : READ_ACCESS;
      EVICT_REQ: begin
        if (mem_req_rdy) state_d = EVICT_WAIT;
      end
      EVICT_WAIT: begin
        if (mem_resp_val) state_d = REFILL_REQ;
      end
      default:       state_d = IDLE;
    endcase
  end

  // ------------------------------------------------------------
  // Output table
  // ------------------------------------------------------------
  always_comb begin
    unique case (state_q)
      //                    req   resp  mreq  mresp cap   rec   lru   fill  store mwr
      IDLE:          co = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      TAG_CHECK:     co = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      READ_ACCESS:   co = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      WRITE_ACCESS:  co = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
      WAIT:          co = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      REFILL_REQ:    co = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      REFILL_WAIT:   co = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      REFILL_UPDATE: co = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
      EVICT_REQ:     co = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
      EVICT_WAIT:    co = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
      default:       co = '0;
    endcase
  end

  assign req_rdy      = co.req_rdy;
  assign resp_val     = co.resp_val;
  assign mem_req_val  = co.mem_req_val;
  assign mem_resp_rdy = co.mem_resp_rdy;
  // Latch only on an actual request transfer
  assign capture      = co.capture && req_val;
  assign record       = co.record;
  assign lru_update   = co.lru_update;
  assign cmd.fill     = co.fill;
  assign cmd.store    = co.store;
  assign mem_is_write = co.mem_is_write;

endmodule

`default_nettype wire

// ==== source/way_select.sv ====
// LRU bits, way record, per-way write enables,
// read word and victim writeback muxing
`timescale 1ns/10ps
`default_nettype none

module way_select
  import cache_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  cache_req_t                          cur,
  input  logic [num_ways-1:0]                 hits,
  input  logic [num_ways-1:0]                 dirties,
  input  logic [num_ways-1:0][tag_bits-1:0]   tags,
  input  logic [num_ways-1:0][line_bits-1:0]  lines,
  input  logic                                record,
  input  logic                                lru_update,
  input  way_cmd_t                            cmd,
  output logic                                hit,
  output logic                                victim_dirty,
  output logic [num_ways-1:0]                 wens,
  output logic [data_bits-1:0]                rd_word,
  output mem_req_t                            victim_req
);

  logic [num_sets-1:0][way_bits-1:0] lru_q;
  logic [way_bits-1:0]               way_q;
  logic [way_bits-1:0]               hit_way;
  logic [way_bits-1:0]               lru_way;
  logic [idx_bits-1:0]               idx;

  assign idx     = cur.addr.f.idx;
  assign lru_way = lru_q[idx];
  assign hit     = |hits;

  // Lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (hits[w]) begin
        hit_way = w[way_bits-1:0];
      end
    end
  end

  assign victim_dirty = dirties[lru_way];

  // ------------------------------------------------------------
  // Way record and LRU state
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      lru_q <= '0;
      way_q <= '0;
    end else begin
      if (record) begin
        way_q <= hit ? hit_way : lru_way;
      end
      // LRU points at the way not used by this access
      if (lru_update) begin
        lru_q[idx] <= ~way_q;
      end
    end
  end

  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      wens[w] = (cmd.fill || cmd.store) && (way_q == w[way_bits-1:0]);
    end
  end

  assign rd_word = lines[way_q][cur.addr.f.word_off*data_bits +: data_bits];

  // Writeback of the recorded victim line
  assign victim_req.op   = op_write;
  assign victim_req.addr = {tags[way_q], idx, {(word_off_bits + byte_off_bits){1'b0}}};
  assign victim_req.data = lines[way_q];

endmodule

`default_nettype wire

// ==== source/cache_way.sv ====
// One cache way: valid, dirty, tag and data arrays,
// hit detection and fill or store writes
`timescale 1ns/10ps
`default_nettype none

module cache_way
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  cache_req_t           cur,
  input  way_cmd_t             cmd,
  input  logic                 wen,
  input  mem_resp_t            fill_line,
  output logic                 hit,
  output logic                 dirty,
  output logic [tag_bits-1:0]  tag,
  output logic [line_bits-1:0] line
);

  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;
  logic [tag_bits-1:0] tag_q [num_sets];
  logic [words_per_line-1:0][data_bits-1:0] data_q [num_sets];

  logic [idx_bits-1:0] idx;

  assign idx = cur.addr.f.idx;

  // ------------------------------------------------------------
  // Combinational read of the indexed entry
  // ------------------------------------------------------------
  assign hit   = valid_q[idx] && (tag_q[idx] == cur.addr.f.tag);
  // A dirty bit only counts on a valid line
  assign dirty = valid_q[idx] && dirty_q[idx];
  assign tag   = tag_q[idx];
  assign line  = data_q[idx];

  // ------------------------------------------------------------
  // Status bits
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (wen) begin
      if (cmd.fill) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;
      end else if (cmd.store) begin
        dirty_q[idx] <= 1'b1;
      end
    end
  end

  // Tag and data storage
  always_ff @(posedge clk) begin
    if (wen) begin
      if (cmd.fill) begin
        tag_q[idx]  <= cur.addr.f.tag;
        data_q[idx] <= fill_line.data;
      end else if (cmd.store) begin
        // merge one word into the line
        data_q[idx][cur.addr.f.word_off] <= cur.data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/req_latch.sv ====
// Request register holding the accepted processor request
// for the whole transaction
`timescale 1ns/10ps
`default_nettype none

module req_latch
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       capture,
  input  cache_req_t req,
  output cache_req_t cur
);

  cache_req_t req_q;

  // Captured on the request transfer, held until the next one
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else if (capture) begin
      req_q <= req;
    end
  end

  // Ways and way selector decode the address union themselves
  assign cur = req_q;

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
// Cache sizes, address union, channel and command structs
// and the controller state type
`default_nettype none

package cache_pkg;

  // ------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------
  localparam int addr_bits      = 32;
  localparam int data_bits      = 32;
  localparam int line_bits      = 128;
  localparam int words_per_line = 4;
  localparam int num_ways       = 2;
  localparam int way_bits       = 1;
  localparam int num_sets       = 8;
  localparam int idx_bits       = 3;
  localparam int tag_bits       = 25;
  localparam int word_off_bits  = 2;
  localparam int byte_off_bits  = 2;

  // Operation encoding shared by both sides
  localparam logic op_read  = 1'b0;
  localparam logic op_write = 1'b1;

  // Same address word, seen raw or split into array fields
  typedef union packed {
    logic [addr_bits-1:0] raw;
    struct packed {
      logic [tag_bits-1:0]      tag;
      logic [idx_bits-1:0]      idx;
      logic [word_off_bits-1:0] word_off;
      logic [byte_off_bits-1:0] byte_off;
    } f;
  } addr_u;

  typedef struct packed {
    logic                 op;
    addr_u                addr;
    logic [data_bits-1:0] data;
  } cache_req_t;

  typedef struct packed {
    logic                 op;
    logic [data_bits-1:0] data;
  } cache_resp_t;

  typedef struct packed {
    logic                 op;
    logic [addr_bits-1:0] addr;
    logic [line_bits-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [line_bits-1:0] data;
  } mem_resp_t;

  // What the chosen way writes this cycle
  typedef struct packed {
    logic fill;
    logic store;
  } way_cmd_t;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE,
    EVICT_REQ,
    EVICT_WAIT
  } ctrl_state_e;

endpackage

`default_nettype wire
